// File: filelist.f
source/decode_pkg.sv
source/inst_decoder.sv
source/stage_register.sv
source/decode_stage.sv
testbench/decode_stage_chk.sv
testbench/tb_decode_stage.sv

// File: Makefile
# Verilator build and run of the decode stage testbench
BIN := obj_dir/Vtb_decode_stage
SOURCES := $(shell grep -v '^+' filelist.f)

.PHONY: all run clean

all: $(BIN)

$(BIN): filelist.f $(SOURCES)
	verilator --binary --timing --assert -j 0 --top-module tb_decode_stage -f filelist.f

run: $(BIN)
	./$(BIN) | awk '{ print } /^TESTBENCH PASSED$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir

// File: testbench/tb_decode_stage.sv
/* Random-stimulus testbench for the decode stage; every delivered entry is
   compared with a decode model through a scoreboard queue */
`timescale 1ns/1ps

module tb_decode_stage;

	localparam int num_offers = 3000;
	localparam int timeout_cycles = num_offers * 10;

	// Expected view of one slot, ordered like the packed DUT outputs below
	typedef struct packed {
		logic inst_valid;
		logic pagefault;
		logic branch_predict;
		logic [31:0] branch_addr;
		logic fault;
		logic [4:0] cmd;
		logic [6:0] unit;
		logic [4:0] source0;
		logic [31:0] source1;
		logic source1_imm;
		logic [4:0] destination;
		logic writeback;
		logic flags_writeback;
	} slot_exp_t;

	typedef struct packed {
		slot_exp_t s0;
		slot_exp_t s1;
		logic [31:0] pc;
	} entry_t;

	logic clock, rst_n, reset_sync, prev_valid, prev_lock, next_valid, next_lock;
	logic prev_0_inst_valid, prev_0_pagefault, prev_0_branch_predict;
	logic prev_1_inst_valid, prev_1_pagefault, prev_1_branch_predict;
	logic [31:0] prev_0_inst, prev_0_branch_predict_addr, prev_1_inst, prev_1_branch_predict_addr;
	logic [31:0] prev_pc, next_pc;
	logic next_0_valid, next_0_fault_pagefault, next_0_fault_invalid_inst, next_0_branch_predict;
	logic next_0_source1_imm, next_0_writeback, next_0_flags_writeback;
	logic [31:0] next_0_branch_predict_addr, next_0_source1;
	logic [4:0] next_0_cmd, next_0_source0, next_0_destination;
	decode_pkg::unit_t next_0_unit;
	logic next_1_valid, next_1_fault_pagefault, next_1_fault_invalid_inst, next_1_branch_predict;
	logic next_1_source1_imm, next_1_writeback, next_1_flags_writeback;
	logic [31:0] next_1_branch_predict_addr, next_1_source1;
	logic [4:0] next_1_cmd, next_1_source0, next_1_destination;
	decode_pkg::unit_t next_1_unit;

	integer seed;
	logic [31:0] rnd;
	entry_t want;
	entry_t exp_q[$];
	int accepted = 0;
	int cycle_count = 0;

	decode_stage i_decode_stage (.*);

	bind decode_stage decode_stage_chk i_decode_stage_chk (
		.clock(clock),
		.rst_n(rst_n),
		.reset_sync(reset_sync),
		.prev_lock(prev_lock),
		.next_valid(next_valid),
		.next_lock(next_lock),
		.next_pc(next_pc),
		.next_0_unit(next_0_unit),
		.next_1_unit(next_1_unit)
	);

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	task automatic report_failure();
		$display("TESTBENCH FAILED");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] want_v);
		assert (got === want_v) else begin
			$display("ERR %s: got %h, expected %h", name, got, want_v);
			report_failure();
		end
	endtask

	// Decode rules: class in [31:29], immediate flag [28], function [27:26]
	function automatic slot_exp_t expected_slot(input logic [31:0] inst, input logic iv,
			input logic pf, input logic bp, input logic [31:0] bpa);
		slot_exp_t s;
		logic [2:0] cls;
		logic imm;
		logic invalid;
		cls = inst[31:29];
		imm = inst[28];
		invalid = (cls == 3'd7) || (cls == 3'd4 && imm);
		s.inst_valid = iv;
		s.pagefault = pf;
		s.branch_predict = bp;
		s.branch_addr = bpa;
		s.fault = invalid;
		s.cmd = {cls, inst[27:26]};
		s.unit = invalid ? 7'd0 : (7'd1 << cls);
		s.source0 = inst[20:16];
		s.destination = inst[25:21];
		s.source1_imm = imm;
		if (!imm) begin
			s.source1 = {27'd0, inst[15:11]};
		end else if (cls == 3'd1 || cls == 3'd2) begin
			s.source1 = {16'd0, inst[15:0]};
		end else begin
			s.source1 = {{16{inst[15]}}, inst[15:0]};
		end
		s.writeback = !invalid && cls != 3'd6 && !(cls == 3'd5 && inst[26]);
		s.flags_writeback = !invalid && (cls == 3'd0 || cls == 3'd1);
		return s;
	endfunction

	task automatic compare_slot(input int idx, input slot_exp_t got, input slot_exp_t w);
		check_value($sformatf("next_%0d_valid", idx), 32'(got.inst_valid), 32'(w.inst_valid));
		check_value($sformatf("next_%0d_fault_pagefault", idx), 32'(got.pagefault), 32'(w.pagefault));
		check_value($sformatf("next_%0d_branch_predict", idx), 32'(got.branch_predict),
			32'(w.branch_predict));
		check_value($sformatf("next_%0d_branch_predict_addr", idx), got.branch_addr, w.branch_addr);
		check_value($sformatf("next_%0d_fault_invalid_inst", idx), 32'(got.fault), 32'(w.fault));
		check_value($sformatf("next_%0d_cmd", idx), 32'(got.cmd), 32'(w.cmd));
		check_value($sformatf("next_%0d_unit", idx), 32'(got.unit), 32'(w.unit));
		check_value($sformatf("next_%0d_source0", idx), 32'(got.source0), 32'(w.source0));
		check_value($sformatf("next_%0d_source1", idx), got.source1, w.source1);
		check_value($sformatf("next_%0d_source1_imm", idx), 32'(got.source1_imm),
			32'(w.source1_imm));
		check_value($sformatf("next_%0d_destination", idx), 32'(got.destination),
			32'(w.destination));
		check_value($sformatf("next_%0d_writeback", idx), 32'(got.writeback), 32'(w.writeback));
		check_value($sformatf("next_%0d_flags_writeback", idx), 32'(got.flags_writeback),
			32'(w.flags_writeback));
	endtask

	task automatic drive_payload();
		rnd = $random(seed);
		prev_0_inst_valid = rnd[0];
		prev_0_pagefault = rnd[1];
		prev_0_branch_predict = rnd[2];
		prev_1_inst_valid = rnd[3];
		prev_1_pagefault = rnd[4];
		prev_1_branch_predict = rnd[5];
		// Full 32-bit draw covers all 64 opcodes
		prev_0_inst = $random(seed);
		prev_1_inst = $random(seed);
		prev_0_branch_predict_addr = $random(seed);
		prev_1_branch_predict_addr = $random(seed);
		prev_pc = $random(seed);
	endtask

	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= timeout_cycles) begin
			$display("Timeout: run did not finish within %0d cycles", timeout_cycles);
			report_failure();
		end
	end

	initial begin
		seed = 63;
		rst_n = 1'b0;
		reset_sync = 1'b0;
		prev_valid = 1'b0;
		next_lock = 1'b0;
		drive_payload();
		repeat (4) @(negedge clock);
		rst_n = 1'b1;
		#1;
		check_value("next_valid", 32'(next_valid), 32'd0);
		check_value("prev_lock", 32'(prev_lock), 32'd0);

		while (accepted < num_offers || exp_q.size() != 0) begin
			@(negedge clock);
			drive_payload();
			rnd = $random(seed);
			reset_sync = (rnd % 100) < 2;
			rnd = $random(seed);
			prev_valid = (rnd % 100) < 70;
			rnd = $random(seed);
			next_lock = (rnd % 100) < 30;
			if (accepted >= num_offers) begin
				// Let the last entry drain
				reset_sync = 1'b0;
				prev_valid = 1'b0;
				next_lock = 1'b0;
			end
			#1;
			// Decide what the coming rising edge does, with all signals settled
			check_value("prev_lock", 32'(prev_lock), 32'(next_valid && next_lock));
			check_value("next_valid", 32'(next_valid), 32'(exp_q.size() != 0));
			if (reset_sync) begin
				exp_q.delete();
			end else begin
				if (next_valid && !next_lock) begin
					want = exp_q.pop_front();
					compare_slot(0, {next_0_valid, next_0_fault_pagefault, next_0_branch_predict,
						next_0_branch_predict_addr, next_0_fault_invalid_inst, next_0_cmd,
						next_0_unit, next_0_source0, next_0_source1, next_0_source1_imm,
						next_0_destination, next_0_writeback, next_0_flags_writeback}, want.s0);
					compare_slot(1, {next_1_valid, next_1_fault_pagefault, next_1_branch_predict,
						next_1_branch_predict_addr, next_1_fault_invalid_inst, next_1_cmd,
						next_1_unit, next_1_source0, next_1_source1, next_1_source1_imm,
						next_1_destination, next_1_writeback, next_1_flags_writeback}, want.s1);
					check_value("next_pc", next_pc, want.pc);
				end
				if (prev_valid && !prev_lock) begin
					want.s0 = expected_slot(prev_0_inst, prev_0_inst_valid, prev_0_pagefault,
						prev_0_branch_predict, prev_0_branch_predict_addr);
					want.s1 = expected_slot(prev_1_inst, prev_1_inst_valid, prev_1_pagefault,
						prev_1_branch_predict, prev_1_branch_predict_addr);
					want.pc = prev_pc;
					exp_q.push_back(want);
					accepted++;
				end
			end
		end

		// Stage empty once the last entry has left
		@(negedge clock);
		#1;
		check_value("next_valid", 32'(next_valid), 32'd0);
		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

// File: testbench/decode_stage_chk.sv
/* Concurrent assertions on the decode stage handshake and outputs, bound into
   the DUT by the testbench */
`timescale 1ns/1ps

module decode_stage_chk (
	input logic clock,
	input logic rst_n,
	input logic reset_sync,
	input logic prev_lock,
	input logic next_valid,
	input logic next_lock,
	input logic [31:0] next_pc,
	input logic [6:0] next_0_unit,
	input logic [6:0] next_1_unit
);

	// Held entry stays put until rename takes it
	assert property (@(posedge clock) disable iff (!rst_n)
		(next_valid && next_lock && !reset_sync) |=> (next_valid && $stable(next_pc)))
		else $error("Held entry changed or vanished while next_lock was high");

	assert property (@(posedge clock) disable iff (!rst_n) prev_lock |-> next_valid)
		else $error("prev_lock high with no entry held");

	// Flush empties the stage
	assert property (@(posedge clock) disable iff (!rst_n) reset_sync |=> !next_valid)
		else $error("Entry still valid one cycle after reset_sync");

	assert property (@(posedge clock) disable iff (!rst_n)
		next_valid |-> ($onehot0(next_0_unit) && $onehot0(next_1_unit)))
		else $error("Unit select is neither one-hot nor zero");

endmodule

// File: source/decode_stage.sv
/* Two-issue decode stage: decodes both fetched instructions and registers them with
   the shared system fields, one entry deep, between fetch and rename */
`timescale 1ns/1ps

module decode_stage (
	input logic clock,
	input logic rst_n,
	input logic reset_sync,
	input logic prev_valid,
	input logic prev_0_inst_valid,
	input logic prev_0_pagefault,
	input logic prev_0_branch_predict,
	input logic [decode_pkg::data_width-1:0] prev_0_branch_predict_addr,
	input logic [decode_pkg::data_width-1:0] prev_0_inst,
	input logic prev_1_inst_valid,
	input logic prev_1_pagefault,
	input logic prev_1_branch_predict,
	input logic [decode_pkg::data_width-1:0] prev_1_branch_predict_addr,
	input logic [decode_pkg::data_width-1:0] prev_1_inst,
	input logic [decode_pkg::data_width-1:0] prev_pc,
	output logic prev_lock,
	output logic next_valid,
	// Slot 0
	output logic next_0_valid,
	output logic next_0_fault_pagefault,
	output logic next_0_fault_invalid_inst,
	output logic next_0_branch_predict,
	output logic [decode_pkg::data_width-1:0] next_0_branch_predict_addr,
	output logic [decode_pkg::cmd_width-1:0] next_0_cmd,
	output decode_pkg::unit_t next_0_unit,
	output logic [decode_pkg::reg_addr_width-1:0] next_0_source0,
	output logic [decode_pkg::data_width-1:0] next_0_source1,
	output logic next_0_source1_imm,
	output logic [decode_pkg::reg_addr_width-1:0] next_0_destination,
	output logic next_0_writeback,
	output logic next_0_flags_writeback,
	// Slot 1
	output logic next_1_valid,
	output logic next_1_fault_pagefault,
	output logic next_1_fault_invalid_inst,
	output logic next_1_branch_predict,
	output logic [decode_pkg::data_width-1:0] next_1_branch_predict_addr,
	output logic [decode_pkg::cmd_width-1:0] next_1_cmd,
	output decode_pkg::unit_t next_1_unit,
	output logic [decode_pkg::reg_addr_width-1:0] next_1_source0,
	output logic [decode_pkg::data_width-1:0] next_1_source1,
	output logic next_1_source1_imm,
	output logic [decode_pkg::reg_addr_width-1:0] next_1_destination,
	output logic next_1_writeback,
	output logic next_1_flags_writeback,
	output logic [decode_pkg::data_width-1:0] next_pc,
	input logic next_lock
);

	decode_pkg::system_payload_t system_in;
	decode_pkg::system_payload_t system_out;
	decode_pkg::slot_payload_t slot_0_in;
	decode_pkg::slot_payload_t slot_0_out;
	decode_pkg::slot_payload_t slot_1_in;
	decode_pkg::slot_payload_t slot_1_out;

	logic system_busy;
	logic slot_0_busy;
	logic slot_1_busy;

	inst_decoder i_decoder_0 (
		.inst(prev_0_inst),
		.fault_invalid_inst(slot_0_in.fault_invalid_inst),
		.cmd(slot_0_in.cmd),
		.unit(slot_0_in.unit),
		.source0(slot_0_in.source0),
		.destination(slot_0_in.destination),
		.source1(slot_0_in.source1),
		.source1_imm(slot_0_in.source1_imm),
		.writeback(slot_0_in.writeback),
		.flags_writeback(slot_0_in.flags_writeback)
	);

	inst_decoder i_decoder_1 (
		.inst(prev_1_inst),
		.fault_invalid_inst(slot_1_in.fault_invalid_inst),
		.cmd(slot_1_in.cmd),
		.unit(slot_1_in.unit),
		.source0(slot_1_in.source0),
		.destination(slot_1_in.destination),
		.source1(slot_1_in.source1),
		.source1_imm(slot_1_in.source1_imm),
		.writeback(slot_1_in.writeback),
		.flags_writeback(slot_1_in.flags_writeback)
	);

	assign slot_0_in.inst_valid = prev_0_inst_valid;
	assign slot_1_in.inst_valid = prev_1_inst_valid;

	// Fetch-side fields that bypass the decoders
	assign system_in = '{
		pagefault_0: prev_0_pagefault,
		branch_predict_0: prev_0_branch_predict,
		branch_predict_addr_0: prev_0_branch_predict_addr,
		pagefault_1: prev_1_pagefault,
		branch_predict_1: prev_1_branch_predict,
		branch_predict_addr_1: prev_1_branch_predict_addr,
		pc: prev_pc
	};

	// All three registers move in lockstep, so their busy strobes agree
	assign prev_lock = system_busy || slot_0_busy || slot_1_busy;

	stage_register #(.payload_t(decode_pkg::system_payload_t)) i_system_reg (
		.clock(clock),
		.rst_n(rst_n),
		.reset_sync(reset_sync),
		.req(prev_valid),
		.data(system_in),
		.busy(system_busy),
		.next_req(next_valid),
		.next_data(system_out),
		.next_busy(next_lock)
	);

	stage_register #(.payload_t(decode_pkg::slot_payload_t)) i_slot_0_reg (
		.clock(clock),
		.rst_n(rst_n),
		.reset_sync(reset_sync),
		.req(prev_valid),
		.data(slot_0_in),
		.busy(slot_0_busy),
		.next_req(),
		.next_data(slot_0_out),
		.next_busy(next_lock)
	);

	stage_register #(.payload_t(decode_pkg::slot_payload_t)) i_slot_1_reg (
		.clock(clock),
		.rst_n(rst_n),
		.reset_sync(reset_sync),
		.req(prev_valid),
		.data(slot_1_in),
		.busy(slot_1_busy),
		.next_req(),
		.next_data(slot_1_out),
		.next_busy(next_lock)
	);

	// Slot 0 outputs
	assign next_0_valid = next_valid && slot_0_out.inst_valid;
	assign next_0_fault_pagefault = system_out.pagefault_0;
	assign next_0_fault_invalid_inst = slot_0_out.fault_invalid_inst;
	assign next_0_branch_predict = system_out.branch_predict_0;
	assign next_0_branch_predict_addr = system_out.branch_predict_addr_0;
	assign next_0_cmd = slot_0_out.cmd;
	assign next_0_unit = slot_0_out.unit;
	assign next_0_source0 = slot_0_out.source0;
	assign next_0_source1 = slot_0_out.source1;
	assign next_0_source1_imm = slot_0_out.source1_imm;
	assign next_0_destination = slot_0_out.destination;
	assign next_0_writeback = slot_0_out.writeback;
	assign next_0_flags_writeback = slot_0_out.flags_writeback;

	// Slot 1 outputs
	assign next_1_valid = next_valid && slot_1_out.inst_valid;
	assign next_1_fault_pagefault = system_out.pagefault_1;
	assign next_1_fault_invalid_inst = slot_1_out.fault_invalid_inst;
	assign next_1_branch_predict = system_out.branch_predict_1;
	assign next_1_branch_predict_addr = system_out.branch_predict_addr_1;
	assign next_1_cmd = slot_1_out.cmd;
	assign next_1_unit = slot_1_out.unit;
	assign next_1_source0 = slot_1_out.source0;
	assign next_1_source1 = slot_1_out.source1;
	assign next_1_source1_imm = slot_1_out.source1_imm;
	assign next_1_destination = slot_1_out.destination;
	assign next_1_writeback = slot_1_out.writeback;
	assign next_1_flags_writeback = slot_1_out.flags_writeback;

	assign next_pc = system_out.pc;

endmodule

// File: source/stage_register.sv
/* One-entry pipeline register with req/busy strobes on both sides and a synchronous
   flush; the payload type is a parameter so one module serves every stage field set */
`timescale 1ns/1ps

module stage_register #(
	parameter type payload_t = logic
) (
	input logic clock,
	input logic rst_n,
	input logic reset_sync,
	input logic req,
	input payload_t data,
	output logic busy,
	output logic next_req,
	output payload_t next_data,
	input logic next_busy
);

	logic valid;
	logic load;
	payload_t payload;

	// Blocked only while holding an entry the next side refuses
	assign busy = valid && next_busy;
	assign load = req && !busy;

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			valid <= 1'b0;
		end else if (reset_sync) begin
			valid <= 1'b0;
		end else if (load) begin
			valid <= 1'b1;
		end else if (!next_busy) begin
			// Entry taken by the next side
			valid <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (load) begin
			payload <= data;
		end
	end

	assign next_req = valid;
	assign next_data = payload;

endmodule

// File: source/inst_decoder.sv
/* Combinational decoder for one 32-bit instruction; produces command, unit select,
   operands, writeback enables and the invalid-instruction fault */
`timescale 1ns/1ps

module inst_decoder (
	input logic [decode_pkg::data_width-1:0] inst,
	output logic fault_invalid_inst,
	output logic [decode_pkg::cmd_width-1:0] cmd,
	output decode_pkg::unit_t unit,
	output logic [decode_pkg::reg_addr_width-1:0] source0,
	output logic [decode_pkg::reg_addr_width-1:0] destination,
	output logic [decode_pkg::data_width-1:0] source1,
	output logic source1_imm,
	output logic writeback,
	output logic flags_writeback
);

	localparam int opcode_width = decode_pkg::opcode_msb - decode_pkg::opcode_lsb + 1;
	localparam int ext_width = decode_pkg::data_width - decode_pkg::imm_width;
	localparam int reg_pad_width = decode_pkg::data_width - decode_pkg::reg_addr_width;

	logic [opcode_width-1:0] opcode;
	logic [decode_pkg::class_width-1:0] op_class;
	logic [decode_pkg::func_width-1:0] func;
	logic imm_flag;
	logic [decode_pkg::imm_width-1:0] imm;
	logic [decode_pkg::reg_addr_width-1:0] src1_reg;

	decode_pkg::unit_t unit_sel;
	logic zero_ext;
	logic wb;
	logic flags_wb;
	logic invalid;

	// Field extraction
	assign opcode = inst[decode_pkg::opcode_msb:decode_pkg::opcode_lsb];
	assign op_class = opcode[opcode_width-1 -: decode_pkg::class_width];
	assign imm_flag = opcode[decode_pkg::imm_flag_bit];
	assign func = opcode[decode_pkg::func_width-1:0];
	assign imm = inst[decode_pkg::imm_width-1:0];
	assign src1_reg = inst[decode_pkg::src1_lsb +: decode_pkg::reg_addr_width];

	assign cmd = {op_class, func};
	assign destination = inst[decode_pkg::dest_lsb +: decode_pkg::reg_addr_width];
	assign source0 = inst[decode_pkg::src0_lsb +: decode_pkg::reg_addr_width];
	assign source1_imm = imm_flag;

	// Per-class attributes
	always_comb begin
		unit_sel = '0;
		zero_ext = 1'b0;
		wb = 1'b1;
		flags_wb = 1'b0;
		invalid = 1'b0;
		case (op_class)
			decode_pkg::class_adder: begin
				unit_sel[decode_pkg::class_adder] = 1'b1;
				flags_wb = 1'b1;
			end
			decode_pkg::class_logic: begin
				unit_sel[decode_pkg::class_logic] = 1'b1;
				flags_wb = 1'b1;
				zero_ext = 1'b1;
			end
			decode_pkg::class_shift: begin
				unit_sel[decode_pkg::class_shift] = 1'b1;
				zero_ext = 1'b1;
			end
			decode_pkg::class_mul: begin
				unit_sel[decode_pkg::class_mul] = 1'b1;
			end
			decode_pkg::class_div: begin
				unit_sel[decode_pkg::class_div] = 1'b1;
				// No immediate form of divide
				invalid = imm_flag;
			end
			decode_pkg::class_ldst: begin
				unit_sel[decode_pkg::class_ldst] = 1'b1;
				// Store has nothing to write back
				wb = !func[0];
			end
			decode_pkg::class_branch: begin
				unit_sel[decode_pkg::class_branch] = 1'b1;
				wb = 1'b0;
			end
			decode_pkg::class_invalid: begin
				invalid = 1'b1;
			end
		endcase
	end

	// Second operand
	always_comb begin
		if (imm_flag) begin
			if (zero_ext) begin
				source1 = {{ext_width{1'b0}}, imm};
			end else begin
				source1 = {{ext_width{imm[decode_pkg::imm_width-1]}}, imm};
			end
		end else begin
			source1 = {{reg_pad_width{1'b0}}, src1_reg};
		end
	end

	// Faulting instruction must not reach a unit or write anything
	assign fault_invalid_inst = invalid;
	assign unit = invalid ? '0 : unit_sel;
	assign writeback = wb && !invalid;
	assign flags_writeback = flags_wb && !invalid;

endmodule

// File: source/decode_pkg.sv
/* Shared widths, instruction field positions, unit classes and stage payload types
   of the two-issue decode stage, referenced by scoped name from the RTL */
package decode_pkg;

	// Datapath widths
	localparam int data_width = 32;
	localparam int reg_addr_width = 5;
	localparam int cmd_width = 5;
	localparam int unit_count = 7;

	// Instruction field positions
	localparam int opcode_msb = 31;
	localparam int opcode_lsb = 26;
	localparam int dest_lsb = 21;
	localparam int src0_lsb = 16;
	localparam int src1_lsb = 11;
	localparam int imm_width = 16;

	// Opcode split: class in the top three bits, then immediate flag, then function
	localparam int class_width = 3;
	localparam int imm_flag_bit = 2;
	localparam int func_width = 2;

	// Unit classes, also the bit index in the one-hot unit select
	localparam logic [class_width-1:0] class_adder = 3'd0;
	localparam logic [class_width-1:0] class_logic = 3'd1;
	localparam logic [class_width-1:0] class_shift = 3'd2;
	localparam logic [class_width-1:0] class_mul = 3'd3;
	localparam logic [class_width-1:0] class_div = 3'd4;
	localparam logic [class_width-1:0] class_ldst = 3'd5;
	localparam logic [class_width-1:0] class_branch = 3'd6;
	localparam logic [class_width-1:0] class_invalid = 3'd7;

	typedef logic [unit_count-1:0] unit_t;

	// Decoded fields of one issue slot
	typedef struct packed {
		logic inst_valid;
		logic fault_invalid_inst;
		logic [cmd_width-1:0] cmd;
		unit_t unit;
		logic [reg_addr_width-1:0] source0;
		logic [data_width-1:0] source1;
		logic source1_imm;
		logic [reg_addr_width-1:0] destination;
		logic writeback;
		logic flags_writeback;
	} slot_payload_t;

	// Fetch-side fields passed straight through, shared PC last
	typedef struct packed {
		logic pagefault_0;
		logic branch_predict_0;
		logic [data_width-1:0] branch_predict_addr_0;
		logic pagefault_1;
		logic branch_predict_1;
		logic [data_width-1:0] branch_predict_addr_1;
		logic [data_width-1:0] pc;
	} system_payload_t;

endpackage
